// ==== verilog/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    // ==================================================
    // Tile geometry
    // ==================================================

    // Processing elements, and windows (output words) per PE
    localparam int pe_count    = 12;
    localparam int win_count   = 7;
    // One weight per PE, then the bias word
    localparam int wload_words = pe_count + 1;
    localparam int iload_words = pe_count * win_count;
    // Each word takes an address cycle and a data cycle
    localparam int wload_cycs  = 2 * wload_words;
    localparam int iload_cycs  = 2 * iload_words;

    // ==================================================
    // Vector types
    // ==================================================

    typedef logic [31:0] word_t;
    typedef logic [14:0] weight_addr_t;
    // Image reads and output writes share one address space
    typedef logic [18:0] feat_addr_t;
    // Bit 0 marks the data phase, upper bits count words
    typedef logic [8:0]  load_cyc_t;
    typedef logic [3:0]  pe_idx_t;
    typedef logic [2:0]  win_idx_t;

    // ==================================================
    // Controller states
    // ==================================================

    typedef enum logic [3:0] {
        s_idle         = 4'd0,
        s_init_preload = 4'd1,
        s_init_swap    = 4'd2,
        s_load_w       = 4'd3,
        s_swap_w       = 4'd4,
        s_load_img     = 4'd5,
        s_swap_img     = 4'd6,
        s_compute      = 4'd7,
        s_wait_out     = 4'd8,
        s_writeback    = 4'd9,
        s_next         = 4'd10,
        s_done         = 4'd11
    } ctrl_state_t;

endpackage

// ==== verilog/conv_sequencer.sv ====
`timescale 1ns/1ps

module conv_sequencer #(
    parameter int n_kernels    = 96,
    parameter int n_row_groups = 56,
    parameter int n_chunks     = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output conv_ctrl_pkg::ctrl_state_t  state,
    output conv_ctrl_pkg::load_cyc_t    load_cyc,
    output logic [6:0]                  kernel_idx,
    output logic [5:0]                  row_group_idx,
    output logic [2:0]                  chunk_idx,
    output conv_ctrl_pkg::win_idx_t     wb_cnt,
    output logic                        prefetch_en,
    output logic [6:0]                  prefetch_kernel,
    output logic                        done,
    output logic                        mmu_valid,
    output logic                        obuf_capture_en
);
    import conv_ctrl_pkg::*;

    ctrl_state_t next_state;
    logic        in_load;
    logic        load_last;
    logic        last_wb;
    logic        last_chunk;
    logic        last_row_group;
    logic        last_kernel;
    logic        tile_wrap;

    // ==================================================
    // Loop bounds
    // ==================================================

    assign last_wb        = (wb_cnt == win_idx_t'(win_count - 1));
    assign last_chunk     = (chunk_idx == 3'(n_chunks - 1));
    assign last_row_group = (row_group_idx == 6'(n_row_groups - 1));
    assign last_kernel    = (kernel_idx == 7'(n_kernels - 1));
    // All tiles of this kernel done
    assign tile_wrap      = last_chunk && last_row_group;

    // Final cycle of each two-phase load state
    always_comb begin
        in_load   = 1'b1;
        load_last = 1'b0;
        case (state)
            s_init_preload, s_load_w:
                load_last = (load_cyc == load_cyc_t'(wload_cycs - 1));
            s_load_img:
                load_last = (load_cyc == load_cyc_t'(iload_cycs - 1));
            default:
                in_load = 1'b0;
        endcase
    end

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        next_state = state;
        case (state)
            s_idle:
                if (start)
                    next_state = s_init_preload;
            s_init_preload:
                if (load_last)
                    next_state = s_init_swap;
            s_init_swap:    next_state = s_load_w;
            s_load_w:
                if (load_last)
                    next_state = s_swap_w;
            s_swap_w:       next_state = s_load_img;
            s_load_img:
                if (load_last)
                    next_state = s_swap_img;
            s_swap_img:     next_state = s_compute;
            s_compute:      next_state = s_wait_out;
            s_wait_out:     next_state = s_writeback;
            s_writeback:
                if (last_wb)
                    next_state = s_next;
            s_next: begin
                // New kernel only once every row group and chunk is through
                if (tile_wrap && last_kernel)
                    next_state = s_done;
                else if (tile_wrap)
                    next_state = s_load_w;
                else
                    next_state = s_load_img;
            end
            // Hold until reset
            s_done:         next_state = s_done;
            default:        next_state = s_idle;
        endcase
    end

    // ==================================================
    // State and counters
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= s_idle;
            load_cyc      <= '0;
            wb_cnt        <= '0;
            chunk_idx     <= '0;
            row_group_idx <= '0;
            kernel_idx    <= '0;
        end else begin
            state    <= next_state;
            // Clears on the last load cycle and outside load states
            load_cyc <= (in_load && !load_last) ? load_cyc + 1'b1 : '0;
            if (state == s_writeback) begin
                wb_cnt <= last_wb ? '0 : wb_cnt + 1'b1;
            end
            // Chunk is the inner loop, then row group, then kernel
            if (state == s_next) begin
                chunk_idx <= last_chunk ? '0 : chunk_idx + 1'b1;
                if (last_chunk) begin
                    row_group_idx <= last_row_group ? '0 : row_group_idx + 1'b1;
                end
                if (tile_wrap && !last_kernel) begin
                    kernel_idx <= kernel_idx + 1'b1;
                end
            end
        end
    end

    // ==================================================
    // Prefetch decision and engine controls
    // ==================================================

    // Kernel 0 during init, then the next kernel behind each weight load
    assign prefetch_en     = (state == s_init_preload) ||
                             ((state == s_load_w) && !last_kernel);
    assign prefetch_kernel = (state == s_load_w) ? kernel_idx + 7'd1 : 7'd0;

    // MMU sees compute and the drain cycle, capture on the drain cycle
    assign mmu_valid       = (state == s_compute) || (state == s_wait_out);
    assign obuf_capture_en = (state == s_wait_out);
    assign done            = (state == s_done);

endmodule

// ==== verilog/weight_store.sv ====
`timescale 1ns/1ps

module weight_store (
    input  logic                        clk,
    input  logic                        rst_n,
    input  conv_ctrl_pkg::ctrl_state_t  state,
    input  conv_ctrl_pkg::load_cyc_t    load_cyc,
    input  logic [6:0]                  kernel_idx,
    input  logic                        prefetch_en,
    input  logic [6:0]                  prefetch_kernel,
    output logic                        ext_weight_rd_en,
    output conv_ctrl_pkg::weight_addr_t ext_weight_rd_addr,
    input  conv_ctrl_pkg::word_t        ext_weight_rd_data,
    output logic                        wbuf_load_en,
    output conv_ctrl_pkg::pe_idx_t      wbuf_load_pe_idx,
    output logic                        wbuf_bias_load_en,
    output conv_ctrl_pkg::word_t        wbuf_load_data,
    output logic                        wbuf_swap
);
    import conv_ctrl_pkg::*;

    // Two banks of one kernel each, active one selected by bank_sel
    word_t      bank_mem [2][wload_words];
    // Kernel number each bank was filled with
    logic [6:0] bank_kernel [2];
    logic       bank_sel;
    word_t      rd_data;
    logic       data_ph;
    pe_idx_t    word_idx;
    logic       shadow_wr;
    logic       active_rd;
    logic       active_ok;
    logic       wload_data;

    assign data_ph  = load_cyc[0];
    // Weight loads never pass word 12, so the low index bits suffice
    assign word_idx = load_cyc[4:1];

    // ==================================================
    // External fetch into the shadow bank
    // ==================================================

    assign ext_weight_rd_en   = prefetch_en && !data_ph;
    assign ext_weight_rd_addr = weight_addr_t'(prefetch_kernel * wload_words)
                              + weight_addr_t'(word_idx);
    // Data comes back one cycle after the request
    assign shadow_wr          = prefetch_en && data_ph;

    always_ff @(posedge clk) begin
        if (shadow_wr) begin
            bank_mem[!bank_sel][word_idx] <= ext_weight_rd_data;
            bank_kernel[!bank_sel]        <= prefetch_kernel;
        end
    end

    // Flips on the init swap and on every weight-buffer swap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_sel <= 1'b0;
        end else if (state == s_init_swap || state == s_swap_w) begin
            bank_sel <= !bank_sel;
        end
    end

    // ==================================================
    // Active bank read toward the weight buffer
    // ==================================================

    // Address phase reads, data phase presents the word
    assign active_rd = (state == s_load_w) && !data_ph;

    always_ff @(posedge clk) begin
        if (active_rd) begin
            rd_data <= bank_mem[bank_sel][word_idx];
        end
    end

    // Active bank must hold the kernel being served
    assign active_ok  = (bank_kernel[bank_sel] == kernel_idx);
    assign wload_data = (state == s_load_w) && data_ph && active_ok;

    // Words 0..11 go to the PEs, word 12 is the bias
    assign wbuf_load_en      = wload_data && (word_idx < pe_idx_t'(pe_count));
    assign wbuf_bias_load_en = wload_data && (word_idx == pe_idx_t'(pe_count));
    assign wbuf_load_pe_idx  = word_idx;
    assign wbuf_load_data    = rd_data;
    assign wbuf_swap         = (state == s_swap_w);

endmodule

// ==== verilog/tile_address_gen.sv ====
`timescale 1ns/1ps

module tile_address_gen #(
    parameter int n_row_groups = 56,
    parameter int n_chunks     = 8
) (
    input  conv_ctrl_pkg::ctrl_state_t  state,
    input  conv_ctrl_pkg::load_cyc_t    load_cyc,
    input  logic [6:0]                  kernel_idx,
    input  logic [5:0]                  row_group_idx,
    input  logic [2:0]                  chunk_idx,
    input  conv_ctrl_pkg::win_idx_t     wb_cnt,
    output logic                        imem_rd_en,
    output conv_ctrl_pkg::feat_addr_t   imem_rd_addr,
    input  conv_ctrl_pkg::word_t        imem_rd_data,
    output logic                        ibuf_load_en,
    output conv_ctrl_pkg::pe_idx_t      ibuf_load_pe_idx,
    output conv_ctrl_pkg::win_idx_t     ibuf_load_win_idx,
    output conv_ctrl_pkg::word_t        ibuf_load_data,
    output logic                        ibuf_swap,
    output logic                        omem_wr_en,
    output conv_ctrl_pkg::feat_addr_t   omem_wr_addr,
    output conv_ctrl_pkg::win_idx_t     obuf_rd_idx
);
    import conv_ctrl_pkg::*;

    // ==================================================
    // Feature-map geometry
    // ==================================================

    // Words in one image row, also one output row
    localparam int row_words = n_chunks * win_count;
    // Four rows per row group in each channel
    localparam int ch_stride = row_words * n_row_groups * 4;
    localparam int k_stride  = n_row_groups * row_words;

    logic [7:0] word_idx;
    pe_idx_t    pe;
    win_idx_t   win;
    logic [1:0] ch;
    logic [7:0] row;
    logic       data_ph;
    logic       img_state;

    assign data_ph   = load_cyc[0];
    assign word_idx  = load_cyc[8:1];
    assign img_state = (state == s_load_img);

    // Word n feeds PE n/7, window n%7
    assign pe  = pe_idx_t'(word_idx / win_count);
    assign win = win_idx_t'(word_idx % win_count);
    // Three channels of four PEs each
    assign ch  = pe[3:2];
    // Row group times 4 plus PE within the channel
    assign row = {row_group_idx, pe[1:0]};

    // ==================================================
    // Image tile load
    // ==================================================

    assign imem_rd_en   = img_state && !data_ph;
    assign imem_rd_addr = feat_addr_t'(ch * ch_stride + row * row_words
                                       + chunk_idx * win_count + win);

    // Same word index in both phases, so PE and window line up with the data
    assign ibuf_load_en      = img_state && data_ph;
    assign ibuf_load_pe_idx  = pe;
    assign ibuf_load_win_idx = win;
    assign ibuf_load_data    = imem_rd_data;
    assign ibuf_swap         = (state == s_swap_img);

    // ==================================================
    // Output writeback
    // ==================================================

    assign omem_wr_en   = (state == s_writeback);
    assign omem_wr_addr = feat_addr_t'(kernel_idx * k_stride + row_group_idx * row_words
                                       + chunk_idx * win_count + wb_cnt);
    // Output buffer word follows the write counter
    assign obuf_rd_idx  = wb_cnt;

endmodule

// ==== verilog/conv_ctrl_top.sv ====
`timescale 1ns/1ps

module conv_ctrl_top #(
    parameter int n_kernels    = 96,
    parameter int n_row_groups = 56,
    parameter int n_chunks     = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    output logic                        done,
    // External weight memory, one-cycle read
    output logic                        ext_weight_rd_en,
    output conv_ctrl_pkg::weight_addr_t ext_weight_rd_addr,
    input  conv_ctrl_pkg::word_t        ext_weight_rd_data,
    // Image memory, one-cycle read
    output logic                        imem_rd_en,
    output conv_ctrl_pkg::feat_addr_t   imem_rd_addr,
    input  conv_ctrl_pkg::word_t        imem_rd_data,
    // Weight buffer
    output logic                        wbuf_load_en,
    output conv_ctrl_pkg::pe_idx_t      wbuf_load_pe_idx,
    output logic                        wbuf_bias_load_en,
    output conv_ctrl_pkg::word_t        wbuf_load_data,
    output logic                        wbuf_swap,
    // Input buffer
    output logic                        ibuf_load_en,
    output conv_ctrl_pkg::pe_idx_t      ibuf_load_pe_idx,
    output conv_ctrl_pkg::win_idx_t     ibuf_load_win_idx,
    output conv_ctrl_pkg::word_t        ibuf_load_data,
    output logic                        ibuf_swap,
    // MMU, output buffer and output memory
    output logic                        mmu_valid,
    output logic                        obuf_capture_en,
    output conv_ctrl_pkg::win_idx_t     obuf_rd_idx,
    output logic                        omem_wr_en,
    output conv_ctrl_pkg::feat_addr_t   omem_wr_addr
);
    import conv_ctrl_pkg::*;

    ctrl_state_t state;
    load_cyc_t   load_cyc;
    logic [6:0]  kernel_idx;
    logic [5:0]  row_group_idx;
    logic [2:0]  chunk_idx;
    win_idx_t    wb_cnt;
    logic        prefetch_en;
    logic [6:0]  prefetch_kernel;

    conv_sequencer #(
        .n_kernels(n_kernels), .n_row_groups(n_row_groups), .n_chunks(n_chunks)
    ) u_sequencer (
        .clk(clk), .rst_n(rst_n), .start(start),
        .state(state), .load_cyc(load_cyc),
        .kernel_idx(kernel_idx), .row_group_idx(row_group_idx),
        .chunk_idx(chunk_idx), .wb_cnt(wb_cnt),
        .prefetch_en(prefetch_en), .prefetch_kernel(prefetch_kernel),
        .done(done), .mmu_valid(mmu_valid), .obuf_capture_en(obuf_capture_en)
    );

    weight_store u_weight_store (
        .clk(clk), .rst_n(rst_n),
        .state(state), .load_cyc(load_cyc), .kernel_idx(kernel_idx),
        .prefetch_en(prefetch_en), .prefetch_kernel(prefetch_kernel),
        .ext_weight_rd_en(ext_weight_rd_en), .ext_weight_rd_addr(ext_weight_rd_addr),
        .ext_weight_rd_data(ext_weight_rd_data),
        .wbuf_load_en(wbuf_load_en), .wbuf_load_pe_idx(wbuf_load_pe_idx),
        .wbuf_bias_load_en(wbuf_bias_load_en), .wbuf_load_data(wbuf_load_data),
        .wbuf_swap(wbuf_swap)
    );

    tile_address_gen #(
        .n_row_groups(n_row_groups), .n_chunks(n_chunks)
    ) u_tile_address_gen (
        .state(state), .load_cyc(load_cyc),
        .kernel_idx(kernel_idx), .row_group_idx(row_group_idx),
        .chunk_idx(chunk_idx), .wb_cnt(wb_cnt),
        .imem_rd_en(imem_rd_en), .imem_rd_addr(imem_rd_addr),
        .imem_rd_data(imem_rd_data),
        .ibuf_load_en(ibuf_load_en), .ibuf_load_pe_idx(ibuf_load_pe_idx),
        .ibuf_load_win_idx(ibuf_load_win_idx), .ibuf_load_data(ibuf_load_data),
        .ibuf_swap(ibuf_swap),
        .omem_wr_en(omem_wr_en), .omem_wr_addr(omem_wr_addr),
        .obuf_rd_idx(obuf_rd_idx)
    );

endmodule

// ==== dv/conv_ctrl_checker.sv ====
`timescale 1ns/1ps

module conv_ctrl_checker #(
    parameter int n_kernels    = 3,
    parameter int n_row_groups = 2,
    parameter int n_chunks     = 2
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        done,
    input  logic                        ext_weight_rd_en,
    input  conv_ctrl_pkg::weight_addr_t ext_weight_rd_addr,
    input  logic                        imem_rd_en,
    input  conv_ctrl_pkg::feat_addr_t   imem_rd_addr,
    input  logic                        wbuf_load_en,
    input  conv_ctrl_pkg::pe_idx_t      wbuf_load_pe_idx,
    input  logic                        wbuf_bias_load_en,
    input  conv_ctrl_pkg::word_t        wbuf_load_data,
    input  logic                        wbuf_swap,
    input  logic                        ibuf_load_en,
    input  conv_ctrl_pkg::pe_idx_t      ibuf_load_pe_idx,
    input  conv_ctrl_pkg::win_idx_t     ibuf_load_win_idx,
    input  conv_ctrl_pkg::word_t        ibuf_load_data,
    input  logic                        ibuf_swap,
    input  logic                        mmu_valid,
    input  logic                        obuf_capture_en,
    input  conv_ctrl_pkg::win_idx_t     obuf_rd_idx,
    input  logic                        omem_wr_en,
    input  conv_ctrl_pkg::feat_addr_t   omem_wr_addr,
    input  logic                        end_check,
    output bit                          done_seen,
    output bit                          report_done,
    output int                          error_count
);
    import conv_ctrl_pkg::*;

    // Row of 7-word chunks, 4 rows per row group in each channel
    localparam int row_words = n_chunks * 7;
    localparam int ch_stride = row_words * n_row_groups * 4;
    localparam int k_stride  = n_row_groups * n_chunks * 7;

    int          exp_fetch[$];
    int          exp_iaddr[$];
    // Kind (0 weight, 1 bias, 2 swap), PE index, data
    logic [37:0] exp_wbuf[$];
    // Swap flag, PE, window, data
    logic [39:0] exp_ibuf[$];
    // Output address, buffer index
    logic [21:0] exp_out[$];
    int          errs[1:5];
    int          checks[1:5];
    bit          closed[1:5];
    bit          started;
    bit          saw_mmu;
    bit          saw_cap;
    int          wr_count;

    // ==================================================
    // Reference model
    // ==================================================

    // Memory contents as the models in the testbench define them
    function automatic word_t weight_word(int addr);
        return word_t'(addr) ^ 32'hA500_0000;
    endfunction

    function automatic word_t image_word(int addr);
        return word_t'(addr) + 32'h1000_0000;
    endfunction

    // Word n sits in PE n/7 and window n%7, channel PE/4 and row group*4 + PE%4
    function automatic int image_addr(int rg, int chunk, int n);
        int pe;
        pe = n / 7;
        return (pe / 4) * ch_stride + (rg * 4 + pe % 4) * row_words + chunk * 7 + n % 7;
    endfunction

    initial begin
        // Init preload fetches kernel 0, each later weight load prefetches k+1
        for (int i = 0; i < 13; i++) begin
            exp_fetch.push_back(i);
        end
        for (int k = 0; k < n_kernels - 1; k++) begin
            for (int i = 0; i < 13; i++) begin
                exp_fetch.push_back((k + 1) * 13 + i);
            end
        end
        for (int k = 0; k < n_kernels; k++) begin
            for (int p = 0; p < 13; p++) begin
                exp_wbuf.push_back({(p == 12) ? 2'd1 : 2'd0, 4'(p), weight_word(k * 13 + p)});
            end
            exp_wbuf.push_back({2'd2, 36'h0});
            // Chunk innermost, then row group
            for (int r = 0; r < n_row_groups; r++) begin
                for (int c = 0; c < n_chunks; c++) begin
                    for (int n = 0; n < 84; n++) begin
                        exp_iaddr.push_back(image_addr(r, c, n));
                        exp_ibuf.push_back({1'b0, 4'(n / 7), 3'(n % 7),
                                            image_word(image_addr(r, c, n))});
                    end
                    exp_ibuf.push_back({1'b1, 39'h0});
                    for (int w = 0; w < 7; w++) begin
                        exp_out.push_back({19'(k * k_stride + r * row_words + c * 7 + w), 3'(w)});
                    end
                end
            end
        end
    end

    // ==================================================
    // Compare helpers
    // ==================================================

    task automatic compare_hex(input int test, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks[test]++;
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            errs[test]++;
        end
    endtask

    task automatic flag_failure(input int test, input string what);
        $display("Error in test %0d: %s at %0t", test, what, $time);
        errs[test]++;
    endtask

    task automatic close_test(input int test, input string title);
        if (!closed[test]) begin
            closed[test] = 1'b1;
            $display("Test %0d %s: %s, %0d checks, %0d errors", test, title,
                     (errs[test] == 0) ? "passed" : "failed", checks[test], errs[test]);
        end
    endtask

    // ==================================================
    // Stream compare, sampled at the rising edge
    // ==================================================

    always @(posedge clk) begin
        logic [37:0] w;
        logic [39:0] ib;
        logic [21:0] o;
        if (rst_n) begin
            // Nothing may move until start is sampled
            if (!started) begin
                compare_hex(1, "idle outputs", {ext_weight_rd_en, imem_rd_en, wbuf_load_en,
                            wbuf_bias_load_en, wbuf_swap, ibuf_load_en, ibuf_swap,
                            mmu_valid, obuf_capture_en, omem_wr_en, done}, 32'h0);
                if (start) begin
                    started = 1'b1;
                    close_test(1, "reset state");
                end
            end
            if (ext_weight_rd_en) begin
                if (exp_fetch.size() == 0) begin
                    flag_failure(2, "weight fetch after the expected stream ended");
                end else begin
                    compare_hex(2, "ext_weight_rd_addr", ext_weight_rd_addr,
                                exp_fetch.pop_front());
                    if (exp_fetch.size() == 0) begin
                        close_test(2, "external fetch stream");
                    end
                end
            end
            // Weight buffer, one event per cycle
            if (wbuf_load_en || wbuf_bias_load_en || wbuf_swap) begin
                if ($countones({wbuf_load_en, wbuf_bias_load_en, wbuf_swap}) > 1) begin
                    flag_failure(3, "more than one weight buffer control high at once");
                end
                if (exp_wbuf.size() == 0) begin
                    flag_failure(3, "weight buffer event after the expected stream ended");
                end else begin
                    w = exp_wbuf.pop_front();
                    compare_hex(3, "{wbuf_swap,wbuf_bias_load_en}",
                                {wbuf_swap, wbuf_bias_load_en}, w[37:36]);
                    if (w[37:36] == 2'd0) begin
                        compare_hex(3, "wbuf_load_pe_idx", wbuf_load_pe_idx, w[35:32]);
                    end
                    if (w[37:36] != 2'd2) begin
                        compare_hex(3, "wbuf_load_data", wbuf_load_data, w[31:0]);
                    end
                    if (exp_wbuf.size() == 0) begin
                        close_test(3, "weight buffer stream");
                    end
                end
            end
            // Image reads and input buffer loads
            if (imem_rd_en) begin
                if (exp_iaddr.size() == 0) begin
                    flag_failure(4, "image read after the expected stream ended");
                end else begin
                    compare_hex(4, "imem_rd_addr", imem_rd_addr, exp_iaddr.pop_front());
                end
            end
            if (ibuf_load_en || ibuf_swap) begin
                if (exp_ibuf.size() == 0) begin
                    flag_failure(4, "input buffer event after the expected stream ended");
                end else begin
                    ib = exp_ibuf.pop_front();
                    compare_hex(4, "ibuf_swap", ibuf_swap, ib[39]);
                    if (!ib[39]) begin
                        compare_hex(4, "ibuf_load_pe_idx", ibuf_load_pe_idx, ib[38:35]);
                        compare_hex(4, "ibuf_load_win_idx", ibuf_load_win_idx, ib[34:32]);
                        compare_hex(4, "ibuf_load_data", ibuf_load_data, ib[31:0]);
                    end
                    if (exp_ibuf.size() == 0 && exp_iaddr.size() == 0) begin
                        close_test(4, "image stream");
                    end
                end
            end
            // MMU and capture must come before each tile's first write
            if (mmu_valid) begin
                saw_mmu = 1'b1;
            end
            if (obuf_capture_en) begin
                saw_cap = 1'b1;
            end
            if (omem_wr_en) begin
                if (wr_count % 7 == 0) begin
                    if (!(saw_mmu && saw_cap)) begin
                        flag_failure(5, "tile writes not preceded by mmu_valid and capture");
                    end
                    saw_mmu = 1'b0;
                    saw_cap = 1'b0;
                end
                wr_count++;
                if (exp_out.size() == 0) begin
                    flag_failure(5, "output write after the expected stream ended");
                end else begin
                    o = exp_out.pop_front();
                    compare_hex(5, "omem_wr_addr", omem_wr_addr, o[21:3]);
                    compare_hex(5, "obuf_rd_idx", obuf_rd_idx, o[2:0]);
                end
            end
            if (done && !done_seen) begin
                if (exp_out.size() != 0) begin
                    flag_failure(5, "done rose before the last output write");
                end
                done_seen <= 1'b1;
            end
            if (done_seen && !done) begin
                flag_failure(5, "done fell after it was raised");
            end
        end
    end

    // ==================================================
    // Closing report
    // ==================================================

    always @(posedge end_check) begin
        int failed;
        int total;
        failed = 0;
        total  = 0;
        if (!started) begin
            flag_failure(1, "start was never sampled");
        end
        if (exp_fetch.size() != 0) begin
            flag_failure(2, $sformatf("%0d weight fetches never issued", exp_fetch.size()));
        end
        if (exp_wbuf.size() != 0) begin
            flag_failure(3, $sformatf("%0d weight buffer events missing", exp_wbuf.size()));
        end
        if (exp_ibuf.size() != 0 || exp_iaddr.size() != 0) begin
            flag_failure(4, "image stream ended early");
        end
        if (!done_seen) begin
            flag_failure(5, "done never rose");
        end
        close_test(1, "reset state");
        close_test(2, "external fetch stream");
        close_test(3, "weight buffer stream");
        close_test(4, "image stream");
        close_test(5, "output stream and done");
        for (int t = 1; t <= 5; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("Summary: 5 tests, %0d passed, %0d failed, %0d errors", 5 - failed, failed, total);
        error_count = total;
        report_done = 1'b1;
    end

endmodule

// ==== dv/conv_ctrl_tb.sv ====
`timescale 1ns/1ps

module conv_ctrl_tb;
    import conv_ctrl_pkg::*;

    // Small geometry, 4 tiles per kernel
    localparam int n_kernels      = 3;
    localparam int n_row_groups   = 2;
    localparam int n_chunks       = 2;
    localparam int max_idle       = 16;
    localparam int hold_cycles    = 8;
    // Init load, then per kernel a weight load and about 180 cycles per tile
    localparam int run_cycles     = 27 + n_kernels * (27 + n_row_groups * n_chunks * 180);
    // 20% margin, plus reset, idle delay and the done hold window
    localparam int timeout_cycles = run_cycles * 6 / 5 + 3 + max_idle + hold_cycles;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         done;
    logic         ext_weight_rd_en;
    weight_addr_t ext_weight_rd_addr;
    word_t        ext_weight_rd_data;
    logic         imem_rd_en;
    feat_addr_t   imem_rd_addr;
    word_t        imem_rd_data;
    logic         wbuf_load_en;
    pe_idx_t      wbuf_load_pe_idx;
    logic         wbuf_bias_load_en;
    word_t        wbuf_load_data;
    logic         wbuf_swap;
    logic         ibuf_load_en;
    pe_idx_t      ibuf_load_pe_idx;
    win_idx_t     ibuf_load_win_idx;
    word_t        ibuf_load_data;
    logic         ibuf_swap;
    logic         mmu_valid;
    logic         obuf_capture_en;
    win_idx_t     obuf_rd_idx;
    logic         omem_wr_en;
    feat_addr_t   omem_wr_addr;
    logic         end_check;
    bit           done_seen;
    bit           report_done;
    int           error_count;
    int           cycle_count = 0;

    conv_ctrl_top #(
        .n_kernels(n_kernels), .n_row_groups(n_row_groups), .n_chunks(n_chunks)
    ) UUT (.*);

    conv_ctrl_checker #(
        .n_kernels(n_kernels), .n_row_groups(n_row_groups), .n_chunks(n_chunks)
    ) u_checker (.*);

    // ==================================================
    // Clock and memory models
    // ==================================================

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Both memories answer one cycle after the read enable
    always @(posedge clk) begin
        if (ext_weight_rd_en) begin
            ext_weight_rd_data <= 32'(ext_weight_rd_addr) ^ 32'hA500_0000;
        end
        if (imem_rd_en) begin
            imem_rd_data <= 32'(imem_rd_addr) + 32'h1000_0000;
        end
    end

    // Hard stop if done never comes
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        int seed;
        int idle;
        seed               = 32'h1c3e64cc;
        rst_n              = 1'b0;
        start              = 1'b0;
        end_check          = 1'b0;
        ext_weight_rd_data = '0;
        imem_rd_data       = '0;
        idle               = $urandom(seed);
        idle               = $urandom % max_idle;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Random quiet gap checks that idle outputs stay low
        repeat (idle) @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait (done_seen);
        // Watch done hold for a few cycles
        repeat (hold_cycles) @(negedge clk);
        end_check = 1'b1;
        wait (report_done);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== conv_ctrl.f ====
verilog/conv_ctrl_pkg.sv
verilog/conv_sequencer.sv
verilog/weight_store.sv
verilog/tile_address_gen.sv
verilog/conv_ctrl_top.sv
dv/conv_ctrl_checker.sv
dv/conv_ctrl_tb.sv
